/* hw/dcachePkg.sv */
package dcachePkg;

  localparam int WORDSPERLINE = 4;
  localparam int NUMWAYS = 2;
  localparam int MAXINDEXBITS = 8;
  // Line address is addr[31:4]; the tag keeps whatever the index does not use
  localparam int TAGBITS = 28;

  typedef logic [31:0] addrWord_t;
  typedef logic [31:0] dataWord_t;
  typedef logic [WORDSPERLINE-1:0][31:0] line_t;

  typedef enum logic [1:0] {OP_READ, OP_WRITE, OP_FLUSH} cpuOp_e;
  typedef enum logic {MEM_READ, MEM_WRITE} memOp_e;

  typedef struct packed {
    cpuOp_e op;
    addrWord_t addr;
    dataWord_t wdata;
    logic [3:0] byteMask;
  } cpuReq_t;

  typedef struct packed {
    logic valid;
    dataWord_t rdata;
  } cpuRsp_t;

  // Word address on the memory side
  typedef struct packed {
    memOp_e op;
    addrWord_t addr;
    dataWord_t wdata;
  } memReq_t;

  typedef struct packed {
    logic valid;
    dataWord_t rdata;
  } memRsp_t;

  typedef struct packed {
    logic [MAXINDEXBITS-1:0] index;
    logic [TAGBITS-1:0] tag;
    logic setValid;
    logic setDirty;
    logic clearDirty;
    logic [1:0] wordSel;
    logic [3:0] byteMask;
    dataWord_t wdata;
    logic tagWrite;
  } wayWrite_t;

  typedef struct packed {
    logic valid;
    logic dirty;
    logic [TAGBITS-1:0] tag;
    line_t data;
  } wayReadout_t;

  function automatic logic [1:0] offsetOf(addrWord_t a);
    return a[3:2];
  endfunction

  function automatic logic [MAXINDEXBITS-1:0] indexOf(addrWord_t a, int unsigned idxBits);
    logic [27:0] lineAddr;
    lineAddr = a[31:4] & ((28'd1 << idxBits) - 28'd1);
    return lineAddr[MAXINDEXBITS-1:0];
  endfunction

  function automatic logic [TAGBITS-1:0] tagOf(addrWord_t a, int unsigned idxBits);
    return a[31:4] >> idxBits;
  endfunction

endpackage

/* hw/cacheWay.sv */
`timescale 1ns/1ps

module cacheWay #(
  parameter int LINES = 16
) (
  input  logic clk,
  input  logic reset,
  input  logic [$clog2(LINES)-1:0] lookupIndex,
  input  dcachePkg::wayWrite_t cmd,
  input  logic we,
  output dcachePkg::wayReadout_t readout
);
  import dcachePkg::*;

  localparam int IDXW = $clog2(LINES);

  logic [TAGBITS-1:0] tagMem [LINES];
  line_t dataMem [LINES];
  logic [LINES-1:0] valid;
  logic [LINES-1:0] dirty;
  logic [IDXW-1:0] writeIdx;

  assign writeIdx = cmd.index[IDXW-1:0];

  // Valid and dirty flags per set
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      valid <= '0;
      dirty <= '0;
    end else if (we) begin
      if (cmd.tagWrite) begin
        valid[writeIdx] <= cmd.setValid;
      end
      if (cmd.setDirty) begin
        dirty[writeIdx] <= 1'b1;
      end else if (cmd.clearDirty) begin
        dirty[writeIdx] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (we) begin
      if (cmd.tagWrite) begin
        tagMem[writeIdx] <= cmd.tag;
      end
      for (int b = 0; b < 4; b++) begin
        if (cmd.byteMask[b]) begin
          dataMem[writeIdx][cmd.wordSel][8*b +: 8] <= cmd.wdata[8*b +: 8];
        end
      end
    end
  end

  // Synchronous read, returns contents from before a same-edge write
  always_ff @(posedge clk) begin
    readout.valid <= valid[lookupIndex];
    readout.dirty <= dirty[lookupIndex];
    readout.tag <= tagMem[lookupIndex];
    readout.data <= dataMem[lookupIndex];
  end

endmodule

/* hw/wayMerge.sv */
`timescale 1ns/1ps

module wayMerge #(
  parameter int LINES = 16
) (
  input  logic clk,
  input  logic reset,
  input  logic [$clog2(LINES)-1:0] lookupIndex,
  input  logic [dcachePkg::TAGBITS-1:0] lookupTag,
  input  dcachePkg::wayReadout_t readouts [dcachePkg::NUMWAYS],
  input  logic touch,
  input  logic touchWay,
  output logic hit,
  output logic hitWay,
  output logic victimWay,
  output logic victimDirty,
  output logic [dcachePkg::TAGBITS-1:0] victimTag,
  output dcachePkg::line_t readLine
);
  import dcachePkg::*;

  // Each bit names the least recently used way of its set
  logic [LINES-1:0] lru;
  logic [NUMWAYS-1:0] wayHit;

  always_comb begin
    for (int i = 0; i < NUMWAYS; i++) begin
      wayHit[i] = readouts[i].valid && (readouts[i].tag == lookupTag);
    end
  end

  assign hit = |wayHit;
  assign hitWay = wayHit[1];

  // Empty way first, then LRU
  always_comb begin
    if (!readouts[0].valid) begin
      victimWay = 1'b0;
    end else if (!readouts[1].valid) begin
      victimWay = 1'b1;
    end else begin
      victimWay = lru[lookupIndex];
    end
  end

  assign victimDirty = readouts[victimWay].valid && readouts[victimWay].dirty;
  assign victimTag = readouts[victimWay].tag;
  assign readLine = hit ? readouts[hitWay].data : readouts[victimWay].data;

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      lru <= '0;
    end else if (touch) begin
      lru[lookupIndex] <= ~touchWay;
    end
  end

endmodule

/* hw/busCreditPort.sv */
`timescale 1ns/1ps

module busCreditPort #(
  parameter int MEMCREDITS = 4
) (
  input  logic clk,
  input  logic reset,
  input  logic beatIssue,
  input  dcachePkg::memReq_t beatReq,
  output logic creditAvail,
  output logic memReqValid,
  output dcachePkg::memReq_t memReq,
  input  logic memCreditReturn
);
  import dcachePkg::*;

  localparam int CW = $clog2(MEMCREDITS + 1);

  logic [CW-1:0] credits;

  assign creditAvail = (credits != '0);

  // Issue and return may land in the same cycle
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      credits <= CW'(MEMCREDITS);
      memReqValid <= 1'b0;
    end else begin
      credits <= credits - CW'(beatIssue) + CW'(memCreditReturn);
      memReqValid <= beatIssue;
    end
  end

  always_ff @(posedge clk) begin
    if (beatIssue) begin
      memReq <= beatReq;
    end
  end

  assert property (@(posedge clk) disable iff (reset) credits <= CW'(MEMCREDITS));

  assert property (@(posedge clk) disable iff (reset) beatIssue |-> credits != '0);

endmodule

/* hw/dcacheController.sv */
`timescale 1ns/1ps

module dcacheController #(
  parameter int LINES = 16
) (
  input  logic clk,
  input  logic reset,
  input  logic cpuReqValid,
  input  dcachePkg::cpuReq_t cpuReq,
  output logic cpuReady,
  output dcachePkg::cpuRsp_t cpuRsp,
  output logic [$clog2(LINES)-1:0] lookupIndex,
  output dcachePkg::wayWrite_t wayCmd,
  output logic [1:0] wayWe,
  input  logic hit,
  input  logic hitWay,
  input  logic victimWay,
  input  logic victimDirty,
  input  logic [dcachePkg::TAGBITS-1:0] victimTag,
  input  dcachePkg::line_t readLine,
  output logic touch,
  output logic touchWay,
  input  logic creditAvail,
  output logic beatIssue,
  output dcachePkg::memReq_t beatReq,
  input  dcachePkg::memRsp_t memRsp
);
  import dcachePkg::*;

  localparam int IDXW = $clog2(LINES);

  typedef enum logic [2:0] {
    IDLE, LOOKUP, WRITEBACK, MEMREAD, RESPOND, FLUSHSCAN, FLUSHWB
  } state_e;

  state_e state, nextState;
  cpuReq_t reqReg;
  logic [IDXW-1:0] reqIndex;
  logic [TAGBITS-1:0] reqTag;
  logic [1:0] reqOffset;
  logic isWrite;

  logic [1:0] issueCnt, recvCnt;
  logic issueDone;
  logic [IDXW-1:0] flushSet;
  logic [1:0] flushStep;
  logic scanArmed;
  logic firstWay;
  logic flushPost, postWay;
  logic [TAGBITS-1:0] postTag;

  logic victimWayReg;
  logic [TAGBITS-1:0] victimTagReg;
  line_t victimLine;
  dataWord_t rspData, fillWord;
  logic [27:0] wbLineAddr;

  assign reqIndex = IDXW'(indexOf(reqReg.addr, IDXW));
  assign reqTag = tagOf(reqReg.addr, IDXW);
  assign reqOffset = offsetOf(reqReg.addr);
  assign isWrite = (reqReg.op == OP_WRITE);

  assign cpuReady = (state == IDLE);
  assign cpuRsp.valid = (state == RESPOND);
  assign cpuRsp.rdata = rspData;

  always_comb begin
    case (state)
      IDLE: lookupIndex = IDXW'(indexOf(cpuReq.addr, IDXW));
      FLUSHSCAN, FLUSHWB: lookupIndex = flushSet;
      default: lookupIndex = reqIndex;
    endcase
  end

  // Victim line address rebuilt from its tag and the current set
  assign wbLineAddr = 28'(victimTagReg << IDXW) | 28'(lookupIndex);

  // Fill word, with the pending CPU write merged in at its offset
  always_comb begin
    fillWord = memRsp.rdata;
    if (isWrite && recvCnt == reqOffset) begin
      for (int b = 0; b < 4; b++) begin
        if (reqReg.byteMask[b]) begin
          fillWord[8*b +: 8] = reqReg.wdata[8*b +: 8];
        end
      end
    end
  end

  // During flush the scan cycle uses the live victim, the writeback path the latched one
  assign postWay = (state == FLUSHSCAN) ? victimWay : victimWayReg;
  assign postTag = (state == FLUSHSCAN) ? victimTag : victimTagReg;

  always_comb begin
    nextState = state;
    wayCmd = '0;
    wayCmd.index = MAXINDEXBITS'(lookupIndex);
    wayCmd.tag = reqTag;
    wayWe = '0;
    touch = 1'b0;
    touchWay = 1'b0;
    beatIssue = 1'b0;
    beatReq = '0;
    flushPost = 1'b0;
    case (state)
      IDLE: begin
        if (cpuReqValid) begin
          nextState = (cpuReq.op == OP_FLUSH) ? FLUSHSCAN : LOOKUP;
        end
      end
      LOOKUP: begin
        if (hit) begin
          touch = 1'b1;
          touchWay = hitWay;
          if (isWrite) begin
            wayWe[hitWay] = 1'b1;
            wayCmd.wordSel = reqOffset;
            wayCmd.byteMask = reqReg.byteMask;
            wayCmd.wdata = reqReg.wdata;
            wayCmd.setDirty = 1'b1;
          end
          nextState = RESPOND;
        end else begin
          nextState = victimDirty ? WRITEBACK : MEMREAD;
        end
      end
      WRITEBACK, FLUSHWB: begin
        if (creditAvail) begin
          beatIssue = 1'b1;
          beatReq.op = MEM_WRITE;
          beatReq.addr = {2'b00, wbLineAddr, issueCnt};
          beatReq.wdata = victimLine[issueCnt];
          if (issueCnt == 2'd3) begin
            if (state == WRITEBACK) begin
              nextState = MEMREAD;
            end else begin
              flushPost = 1'b1;
              nextState = FLUSHSCAN;
            end
          end
        end
      end
      MEMREAD: begin
        if (creditAvail && !issueDone) begin
          beatIssue = 1'b1;
          beatReq.op = MEM_READ;
          beatReq.addr = {2'b00, reqReg.addr[31:4], issueCnt};
        end
        if (memRsp.valid) begin
          wayWe[victimWayReg] = 1'b1;
          wayCmd.wordSel = recvCnt;
          wayCmd.byteMask = 4'hf;
          wayCmd.wdata = fillWord;
          if (recvCnt == 2'd3) begin
            wayCmd.tagWrite = 1'b1;
            wayCmd.setValid = 1'b1;
            wayCmd.setDirty = isWrite;
            wayCmd.clearDirty = !isWrite;
            touch = 1'b1;
            touchWay = victimWayReg;
            nextState = RESPOND;
          end
        end
      end
      RESPOND: nextState = IDLE;
      FLUSHSCAN: begin
        // Matching on the victim's own tag steers readLine to the victim
        wayCmd.tag = victimTag;
        if (flushStep == 2'd2) begin
          // Drop the way handled in the first pass
          wayWe[firstWay] = 1'b1;
          wayCmd.tagWrite = 1'b1;
          wayCmd.clearDirty = 1'b1;
          if (flushSet == IDXW'(LINES - 1)) begin
            nextState = RESPOND;
          end
        end else if (scanArmed) begin
          if (victimDirty) begin
            nextState = FLUSHWB;
          end else begin
            flushPost = 1'b1;
          end
        end
      end
      default: nextState = IDLE;
    endcase

    // First pass keeps the way valid and most recent, so the second pass sees the other one
    if (flushPost) begin
      wayWe[postWay] = 1'b1;
      wayCmd.tagWrite = 1'b1;
      wayCmd.tag = postTag;
      wayCmd.setValid = (flushStep == 2'd0);
      wayCmd.clearDirty = 1'b1;
      if (flushStep == 2'd0) begin
        touch = 1'b1;
        touchWay = postWay;
      end
    end
  end

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      state <= IDLE;
      issueCnt <= '0;
      recvCnt <= '0;
      issueDone <= 1'b0;
      flushSet <= '0;
      flushStep <= '0;
      scanArmed <= 1'b0;
      firstWay <= 1'b0;
    end else begin
      state <= nextState;
      if (beatIssue) begin
        issueCnt <= issueCnt + 2'd1;
        if (state == MEMREAD && issueCnt == 2'd3) begin
          issueDone <= 1'b1;
        end
      end
      if (state == MEMREAD && memRsp.valid) begin
        recvCnt <= recvCnt + 2'd1;
      end
      if (state == LOOKUP) begin
        issueCnt <= '0;
        recvCnt <= '0;
        issueDone <= 1'b0;
      end
      if (state == IDLE) begin
        flushSet <= '0;
        flushStep <= '0;
        scanArmed <= 1'b0;
      end
      if (state == FLUSHSCAN) begin
        if (flushStep == 2'd2) begin
          flushStep <= '0;
          flushSet <= flushSet + 1'b1;
        end else begin
          // One idle cycle lets the readout catch up with the index or a write
          scanArmed <= !scanArmed;
        end
      end
      if (flushPost) begin
        flushStep <= flushStep + 2'd1;
        if (flushStep == 2'd0) begin
          firstWay <= postWay;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cpuReqValid && cpuReady) begin
      reqReg <= cpuReq;
    end
    if ((state == LOOKUP && !hit) || (state == FLUSHSCAN && scanArmed && flushStep != 2'd2)) begin
      victimWayReg <= victimWay;
      victimTagReg <= victimTag;
      victimLine <= readLine;
    end
    if (state == LOOKUP && hit) begin
      rspData <= readLine[reqOffset];
    end
    if (state == MEMREAD && memRsp.valid && recvCnt == reqOffset) begin
      rspData <= fillWord;
    end
  end

  // Only one way may be written in any cycle
  assert property (@(posedge clk) disable iff (reset) !(&wayWe));

endmodule

/* hw/dcacheTop.sv */
`timescale 1ns/1ps

module dcacheTop #(
  parameter int LINES = 16,
  parameter int MEMCREDITS = 4
) (
  input  logic clk,
  input  logic reset,
  input  logic cpuReqValid,
  input  dcachePkg::cpuReq_t cpuReq,
  output logic cpuReady,
  output dcachePkg::cpuRsp_t cpuRsp,
  output logic memReqValid,
  output dcachePkg::memReq_t memReq,
  input  logic memCreditReturn,
  input  dcachePkg::memRsp_t memRsp
);
  import dcachePkg::*;

  logic [$clog2(LINES)-1:0] lookupIndex;
  wayWrite_t wayCmd;
  logic [NUMWAYS-1:0] wayWe;
  wayReadout_t readouts [NUMWAYS];
  logic hit, hitWay, victimWay, victimDirty;
  logic [TAGBITS-1:0] victimTag;
  line_t readLine;
  logic touch, touchWay;
  logic creditAvail, beatIssue;
  memReq_t beatReq;

  dcacheController #(.LINES(LINES)) controller (
    .clk, .reset, .cpuReqValid, .cpuReq, .cpuReady, .cpuRsp,
    .lookupIndex, .wayCmd, .wayWe,
    .hit, .hitWay, .victimWay, .victimDirty, .victimTag, .readLine,
    .touch, .touchWay, .creditAvail, .beatIssue, .beatReq, .memRsp
  );

  for (genvar w = 0; w < NUMWAYS; w++) begin : gWay
    cacheWay #(.LINES(LINES)) way (
      .clk, .reset, .lookupIndex,
      .cmd(wayCmd),
      .we(wayWe[w]),
      .readout(readouts[w])
    );
  end

  // Command tag carries the request tag during lookup
  wayMerge #(.LINES(LINES)) merge (
    .clk, .reset, .lookupIndex,
    .lookupTag(wayCmd.tag),
    .readouts,
    .touch, .touchWay,
    .hit, .hitWay, .victimWay, .victimDirty, .victimTag, .readLine
  );

  busCreditPort #(.MEMCREDITS(MEMCREDITS)) busPort (
    .clk, .reset, .beatIssue, .beatReq, .creditAvail,
    .memReqValid, .memReq, .memCreditReturn
  );

endmodule

/* verif/memResponder.sv */
`timescale 1ns/1ps

module memResponder #(
  parameter logic [31:0] SEED = 32'h1,
  parameter int MEMWORDS = 1024
) (
  input  logic clk,
  input  logic reset,
  input  logic throttle,
  input  logic memReqValid,
  input  dcachePkg::memReq_t memReq,
  output logic memCreditReturn,
  output dcachePkg::memRsp_t memRsp
);
  import dcachePkg::*;

  localparam int AW = $clog2(MEMWORDS);

  dataWord_t memArray [MEMWORDS];
  dataWord_t rdData [$];
  int rdTime [$];
  int creditTime [$];
  int now, lastRsp, lastCredit, delay, rspAt, credAt;
  int outstanding, maxOutstanding;
  logic [31:0] lcgState;
  dataWord_t rspWord;

  function automatic logic [31:0] stepLcg(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  always @(posedge clk or posedge reset) begin
    if (reset) begin
      // Initial content follows the word address
      for (int i = 0; i < MEMWORDS; i++) begin
        memArray[i] = 32'(i) ^ 32'h5a5a0000;
      end
      rdData.delete();
      rdTime.delete();
      creditTime.delete();
      now = 0;
      lastRsp = 0;
      lastCredit = 0;
      outstanding = 0;
      maxOutstanding = 0;
      lcgState = SEED;
      memCreditReturn <= 1'b0;
      memRsp <= '0;
    end else begin
      now = now + 1;
      memCreditReturn <= 1'b0;
      memRsp <= '0;
      if (memReqValid) begin
        lcgState = stepLcg(lcgState);
        delay = int'(lcgState[18:16]) % 6;
        // Throttle mode holds every credit much longer
        if (throttle) begin
          delay = delay + 8;
        end
        if (memReq.op == MEM_WRITE) begin
          memArray[memReq.addr[AW-1:0]] = memReq.wdata;
          credAt = now + 1 + delay;
        end else begin
          rspAt = now + 1 + int'(lcgState[26:24]);
          rspAt = (rspAt > lastRsp) ? rspAt : lastRsp + 1;
          lastRsp = rspAt;
          rdData.push_back(memArray[memReq.addr[AW-1:0]]);
          rdTime.push_back(rspAt);
          // A read slot frees only once its data is out
          credAt = rspAt + delay;
        end
        credAt = (credAt > lastCredit) ? credAt : lastCredit + 1;
        lastCredit = credAt;
        creditTime.push_back(credAt);
        outstanding = outstanding + 1;
        maxOutstanding = (outstanding > maxOutstanding) ? outstanding : maxOutstanding;
      end
      if (rdTime.size() > 0 && rdTime[0] <= now) begin
        void'(rdTime.pop_front());
        rspWord = rdData.pop_front();
        memRsp <= '{valid: 1'b1, rdata: rspWord};
      end
      if (creditTime.size() > 0 && creditTime[0] <= now) begin
        void'(creditTime.pop_front());
        outstanding = outstanding - 1;
        memCreditReturn <= 1'b1;
      end
    end
  end

endmodule

/* verif/dcacheTb.sv */
`timescale 1ns/1ps

module dcacheTb;
  import dcachePkg::*;

  localparam int MEMWORDS = 1024;
  localparam int TIMEOUT = 5000;

  logic clk;
  logic reset;
  logic cpuReqValid;
  cpuReq_t cpuReq;
  logic cpuReady;
  cpuRsp_t cpuRsp;
  logic memReqValid;
  memReq_t memReq;
  logic memCreditReturn;
  memRsp_t memRsp;
  logic throttle;
  logic [31:0] lcgState;
  dataWord_t model [MEMWORDS];

  dcacheTop #(.LINES(16), .MEMCREDITS(4)) UUT (
    .clk, .reset, .cpuReqValid, .cpuReq, .cpuReady, .cpuRsp,
    .memReqValid, .memReq, .memCreditReturn, .memRsp
  );

  memResponder #(.SEED(32'h84a21023), .MEMWORDS(MEMWORDS)) memory (
    .clk, .reset, .throttle, .memReqValid, .memReq, .memCreditReturn, .memRsp
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  // Eight tags over sets 0 to 3 keep both ways busy and force evictions
  function automatic addrWord_t randAddr(logic [31:0] r);
    return {21'd0, r[30:28], 2'b00, r[25:24], r[21:20], 2'b00};
  endfunction

  task automatic failRun(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic checkWord(input string name, input dataWord_t expected, input dataWord_t actual);
    if (actual !== expected) begin
      failRun($sformatf("ERR %s expected %08h actual %08h", name, expected, actual));
    end
  endtask

  task automatic checkFlag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      failRun($sformatf("ERR %s expected %0b actual %0b", name, expected, actual));
    end
  endtask

  task automatic applyWrite(input addrWord_t addr, input dataWord_t wdata, input logic [3:0] mask);
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) begin
        model[addr[11:2]][8*b +: 8] = wdata[8*b +: 8];
      end
    end
  endtask

  // Cycles counts negedges from the accepting edge up to the response
  task automatic runOp(input cpuOp_e op, input addrWord_t addr, input dataWord_t wdata,
                       input logic [3:0] mask, output dataWord_t rdata, output int cycles);
    int waitCnt;
    logic rspSeen;
    @(posedge clk);
    cpuReqValid <= 1'b1;
    cpuReq <= '{op: op, addr: addr, wdata: wdata, byteMask: mask};
    waitCnt = 0;
    @(negedge clk);
    while (!cpuReady) begin
      waitCnt++;
      if (waitCnt > TIMEOUT) failRun("CPU request was never accepted");
      @(negedge clk);
    end
    @(posedge clk);
    cpuReqValid <= 1'b0;
    cycles = 0;
    rspSeen = 1'b0;
    while (!rspSeen) begin
      @(negedge clk);
      cycles++;
      rspSeen = cpuRsp.valid;
      if (!rspSeen && cycles > TIMEOUT) failRun("CPU response never arrived");
    end
    rdata = cpuRsp.rdata;
  endtask

  task automatic randomOp();
    logic [31:0] r;
    addrWord_t addr;
    dataWord_t wdata;
    dataWord_t rdata;
    int cycles;
    r = nextRand();
    addr = randAddr(r);
    wdata = nextRand();
    if (r[31]) begin
      runOp(OP_WRITE, addr, wdata, r[15:12], rdata, cycles);
      applyWrite(addr, wdata, r[15:12]);
    end else begin
      runOp(OP_READ, addr, '0, 4'h0, rdata, cycles);
      checkWord("randomRead", model[addr[11:2]], rdata);
    end
    // Same address right after must hit
    if (r[19:18] == 2'd0) begin
      runOp(OP_READ, addr, '0, 4'h0, rdata, cycles);
      checkWord("repeatRead", model[addr[11:2]], rdata);
      checkFlag("hitLatency", 1'b1, cycles == 2);
    end
  endtask

  initial begin
    dataWord_t rdata;
    addrWord_t addr;
    int cycles;
    clk = 1'b0;
    reset = 1'b1;
    cpuReqValid = 1'b0;
    cpuReq = '0;
    throttle = 1'b0;
    lcgState = 32'h84a21023;
    for (int i = 0; i < MEMWORDS; i++) begin
      model[i] = 32'(i) ^ 32'h5a5a0000;
    end
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    @(negedge clk);
    checkFlag("resetReady", 1'b1, cpuReady);
    checkFlag("resetRspValid", 1'b0, cpuRsp.valid);
    checkFlag("resetMemReqValid", 1'b0, memReqValid);
    // Outside the random address set
    addr = 32'h0000_0a9c;
    runOp(OP_READ, addr, '0, 4'h0, rdata, cycles);
    checkWord("untouchedRead", model[addr[11:2]], rdata);
    checkFlag("coldMiss", 1'b1, cycles > 2);

    for (int n = 0; n < 400; n++) begin
      randomOp();
    end

    // Memory must hold every dirty word after a flush
    runOp(OP_FLUSH, '0, '0, 4'h0, rdata, cycles);
    for (int i = 0; i < MEMWORDS; i++) begin
      checkWord($sformatf("flushMem[%0d]", i), model[i], memory.memArray[i]);
    end
    addr = randAddr(nextRand());
    runOp(OP_READ, addr, '0, 4'h0, rdata, cycles);
    checkWord("readAfterFlush", model[addr[11:2]], rdata);
    checkFlag("missAfterFlush", 1'b1, cycles > 2);

    @(posedge clk);
    throttle <= 1'b1;
    for (int n = 0; n < 120; n++) begin
      randomOp();
    end
    checkFlag("creditLimit", 1'b1, memory.maxOutstanding <= 4);
    checkFlag("creditsExhausted", 1'b1, memory.maxOutstanding == 4);

    $display("All tests passed!");
    $finish;
  end

endmodule

/* dcacheTop.f */
hw/dcachePkg.sv
hw/cacheWay.sv
hw/wayMerge.sv
hw/busCreditPort.sv
hw/dcacheController.sv
hw/dcacheTop.sv
verif/memResponder.sv
verif/dcacheTb.sv

/* runSim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and judge the run from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module dcacheTb \
  -f dcacheTop.f -o dcacheSim > build.log 2>&1 \
  && ./obj_dir/dcacheSim > sim.log 2>&1 \
  || echo "Test failures found" >> sim.log
cat sim.log
if grep -q "Test failures found" sim.log; then
  echo "Simulation failed, see build.log and sim.log"
  exit 1
fi
echo "Simulation passed"
exit 0
